// ==== flist.f ====
hdl/bus_pkg.sv
hdl/clint.sv
hdl/bus_arbiter.sv
hdl/cpu_bus_top.sv
dv/axi_mem_model.sv
dv/cpu_bus_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_bus

sources:
  - files:
      - hdl/bus_pkg.sv
      - hdl/clint.sv
      - hdl/bus_arbiter.sv
      - hdl/cpu_bus_top.sv
  - target: test
    files:
      - dv/axi_mem_model.sv
      - dv/cpu_bus_tb.sv

// ==== dv/cpu_bus_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_tb;
  import bus_pkg::*;

  localparam int          ADDR_W   = 32;
  localparam int          DEPTH    = 256;
  localparam logic [63:0] KEY      = 64'h5a5a_c3c3_0f0f_9696;
  localparam logic [31:0] BASE     = 32'h8000_0000;
  localparam int          RST_CYC  = 10;
  localparam int          N_IFU    = 24;
  localparam int          N_LOAD   = 48;
  localparam int          N_STORE  = 24;
  localparam int          N_TIMER  = 8;
  localparam int          N_CONC   = 16;
  localparam int          N_TXN    = N_IFU + N_LOAD + 2 * N_STORE + N_TIMER + 2 * N_CONC;
  // kind of lsu load in flight
  localparam logic [1:0]  K_MEM    = 2'd0;
  localparam logic [1:0]  K_LO     = 2'd1;
  localparam logic [1:0]  K_HI     = 2'd2;

  logic clk;
  logic rst;
  logic [ADDR_W-1:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i;
  logic ifu_arvalid_i, lsu_arvalid_i, lsu_wvalid_i;
  logic [7:0] lsu_rstrb_i, lsu_wstrb_i;
  logic [31:0] lsu_wdata_i;
  wire [31:0] ifu_rdata_o, lsu_rdata_o;
  wire ifu_rvalid_o, lsu_rvalid_o, lsu_wdone_o;
  wire [ADDR_W-1:0] m_araddr, m_awaddr;
  wire [2:0] m_arsize, m_awsize;
  wire m_arvalid, m_arready, m_rvalid, m_rready, m_awvalid, m_awready;
  wire m_wvalid, m_wready, m_wlast, m_bvalid, m_bready;
  wire [63:0] m_rdata, m_wdata;
  wire [7:0] m_wstrb;
  wire [1:0] m_rresp, m_bresp;

  // expectations and bookkeeping
  logic [63:0] shadow [DEPTH];
  logic [31:0] exp_ifu, exp_lsu, last_lo;
  logic [1:0]  lsu_kind;
  logic [2:0]  exp_arsize, exp_awsize;
  logic        ifu_pend, lsu_pend, wr_pend, conc_mode;
  string       test_name;
  int          n_ifu, n_mem, n_lo, n_hi, n_store, n_conc;

  cpu_bus_top #(.ADDR_W(ADDR_W)) dut0 (
    .clk(clk), .rst(rst),
    .ifu_araddr_i(ifu_araddr_i), .ifu_arvalid_i(ifu_arvalid_i),
    .ifu_rdata_o(ifu_rdata_o), .ifu_rvalid_o(ifu_rvalid_o),
    .lsu_araddr_i(lsu_araddr_i), .lsu_arvalid_i(lsu_arvalid_i), .lsu_rstrb_i(lsu_rstrb_i),
    .lsu_rdata_o(lsu_rdata_o), .lsu_rvalid_o(lsu_rvalid_o),
    .lsu_awaddr_i(lsu_awaddr_i), .lsu_wdata_i(lsu_wdata_i), .lsu_wstrb_i(lsu_wstrb_i),
    .lsu_wvalid_i(lsu_wvalid_i), .lsu_wdone_o(lsu_wdone_o),
    .m_araddr_o(m_araddr), .m_arsize_o(m_arsize), .m_arvalid_o(m_arvalid),
    .m_arready_i(m_arready), .m_rdata_i(m_rdata), .m_rresp_i(m_rresp),
    .m_rvalid_i(m_rvalid), .m_rready_o(m_rready),
    .m_awaddr_o(m_awaddr), .m_awsize_o(m_awsize), .m_awvalid_o(m_awvalid),
    .m_awready_i(m_awready), .m_wdata_o(m_wdata), .m_wstrb_o(m_wstrb), .m_wlast_o(m_wlast),
    .m_wvalid_o(m_wvalid), .m_wready_i(m_wready), .m_bresp_i(m_bresp),
    .m_bvalid_i(m_bvalid), .m_bready_o(m_bready)
  );

  axi_mem_model #(.ADDR_W(ADDR_W), .DEPTH(DEPTH), .KEY(KEY)) u_mem (
    .clk(clk), .rst(rst),
    .araddr_i(m_araddr), .arvalid_i(m_arvalid), .arready_o(m_arready),
    .rdata_o(m_rdata), .rresp_o(m_rresp), .rvalid_o(m_rvalid), .rready_i(m_rready),
    .awaddr_i(m_awaddr), .awvalid_i(m_awvalid), .awready_o(m_awready),
    .wdata_i(m_wdata), .wstrb_i(m_wstrb), .wvalid_i(m_wvalid), .wready_o(m_wready),
    .bresp_o(m_bresp), .bvalid_o(m_bvalid), .bready_i(m_bready)
  );

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1);
  endtask

  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[10:3]);
  endfunction

  // half by bit 2, shifted down by the byte offset
  function automatic logic [31:0] lane_read(input logic [63:0] w, input logic [31:0] addr);
    logic [31:0] half;
    half = addr[2] ? w[63:32] : w[31:0];
    return half >> (8 * addr[1:0]);
  endfunction

  // byte-wise merge of a store into a shadow word
  function automatic logic [63:0] merge_store(input logic [63:0] w, input logic [31:0] addr,
                                              input logic [31:0] data, input logic [7:0] strb);
    logic [63:0] r;
    logic [31:0] sdata;
    logic [7:0]  smask;
    r     = w;
    sdata = data << (8 * addr[1:0]);
    smask = {4'b0000, strb[3:0]} << addr[1:0];
    for (int b = 0; b < 4; b++)
      begin
        if (smask[b])
          begin
            r[32*addr[2] + 8*b +: 8] = sdata[8*b +: 8];
          end
      end
    return r;
  endfunction

  function automatic logic [7:0] strb_for(input int sz);
    return (sz == 0) ? 8'h01 : (sz == 1) ? 8'h03 : 8'h0f;
  endfunction

  // axi size is log2 of the bytes enabled
  function automatic logic [2:0] axi_size(input logic [7:0] strb);
    int n;
    n = 0;
    for (int b = 0; b < 8; b++)
      begin
        n += int'(strb[b]);
      end
    return 3'($clog2(n));
  endfunction

  function automatic logic [31:0] rand_addr();
    return BASE | ($urandom & 32'h0000_07ff);
  endfunction

  task automatic read_ifu(input logic [31:0] addr);
    @(posedge clk);
    exp_ifu       <= lane_read(shadow[word_index(addr)], {addr[31:2], 2'b00});
    ifu_araddr_i  <= addr;
    ifu_arvalid_i <= 1'b1;
    ifu_pend      <= 1'b1;
    do
      @(posedge clk);
    while (!ifu_rvalid_o);
    ifu_arvalid_i <= 1'b0;
    ifu_pend      <= 1'b0;
    n_ifu++;
  endtask

  task automatic load_lsu(input logic [31:0] addr, input logic [7:0] strb,
                          input logic [1:0] kind);
    @(posedge clk);
    exp_lsu       <= lane_read(shadow[word_index(addr)], addr);
    exp_arsize    <= axi_size(strb);
    lsu_kind      <= kind;
    lsu_araddr_i  <= addr;
    lsu_rstrb_i   <= strb;
    lsu_arvalid_i <= 1'b1;
    lsu_pend      <= 1'b1;
    do
      @(posedge clk);
    while (!lsu_rvalid_o);
    lsu_arvalid_i <= 1'b0;
    lsu_pend      <= 1'b0;
    if (kind == K_LO)
      begin
        last_lo <= lsu_rdata_o;
        n_lo++;
      end
    else if (kind == K_HI)
      n_hi++;
    else
      n_mem++;
  endtask

  task automatic store_lsu(input logic [31:0] addr, input logic [31:0] data,
                           input logic [7:0] strb);
    @(posedge clk);
    exp_awsize   <= axi_size(strb);
    lsu_awaddr_i <= addr;
    lsu_wdata_i  <= data;
    lsu_wstrb_i  <= strb;
    lsu_wvalid_i <= 1'b1;
    wr_pend      <= 1'b1;
    do
      @(posedge clk);
    while (!lsu_wdone_o);
    lsu_wvalid_i <= 1'b0;
    wr_pend      <= 1'b0;
    shadow[word_index(addr)] = merge_store(shadow[word_index(addr)], addr, data, strb);
    n_store++;
  endtask

  // checks on every response
  a_ifu_data: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o |-> ifu_rdata_o == exp_ifu)
    else stop_with_failure($sformatf("error %s: expected %h actual %h",
      test_name, $sampled(exp_ifu), $sampled(ifu_rdata_o)));

  a_lsu_data: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o && lsu_kind == K_MEM |-> lsu_rdata_o == exp_lsu)
    else stop_with_failure($sformatf("error %s: expected %h actual %h",
      test_name, $sampled(exp_lsu), $sampled(lsu_rdata_o)));

  a_mtime_rising: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o && lsu_kind == K_LO |-> lsu_rdata_o > last_lo)
    else stop_with_failure($sformatf("error %s: expected above %h actual %h",
      test_name, $sampled(last_lo), $sampled(lsu_rdata_o)));

  a_mtime_hi_zero: assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid_o && lsu_kind == K_HI |-> lsu_rdata_o == 32'h0)
    else stop_with_failure($sformatf("error %s: expected %h actual %h",
      test_name, 32'h0, $sampled(lsu_rdata_o)));

  // timer load, one cycle to issue and one in the timer
  a_timer_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(lsu_arvalid_i) && (lsu_araddr_i == mtime_lo_addr || lsu_araddr_i == mtime_hi_addr)
    |-> !lsu_rvalid_o ##1 !lsu_rvalid_o ##1 lsu_rvalid_o)
    else stop_with_failure("timer load did not complete two cycles after its request");

  a_ifu_once: assert property (@(posedge clk) disable iff (rst) ifu_rvalid_o |-> ifu_pend)
    else stop_with_failure("ifu data pulse with no fetch outstanding");
  a_lsu_once: assert property (@(posedge clk) disable iff (rst) lsu_rvalid_o |-> lsu_pend)
    else stop_with_failure("lsu data pulse with no load outstanding");
  a_wdone_once: assert property (@(posedge clk) disable iff (rst) lsu_wdone_o |-> wr_pend)
    else stop_with_failure("store done pulse with no store outstanding");

  a_lsu_first: assert property (@(posedge clk) disable iff (rst)
    ifu_rvalid_o && conc_mode |-> !lsu_pend)
    else stop_with_failure("ifu fetch finished before the competing lsu load");

  // fetches are whole words, loads follow their strobes
  a_arsize: assert property (@(posedge clk) disable iff (rst)
    m_arvalid |-> m_arsize == (lsu_pend ? exp_arsize : size_word))
    else stop_with_failure($sformatf("error %s: expected %h actual %h",
      test_name, $sampled(lsu_pend) ? $sampled(exp_arsize) : size_word, $sampled(m_arsize)));

  a_awsize: assert property (@(posedge clk) disable iff (rst)
    m_awvalid |-> m_awsize == exp_awsize)
    else stop_with_failure($sformatf("error %s: expected %h actual %h",
      test_name, $sampled(exp_awsize), $sampled(m_awsize)));

  // single-beat writes
  a_wlast: assert property (@(posedge clk) disable iff (rst) m_wvalid |-> m_wlast)
    else stop_with_failure("write beat sent without wlast");

  initial
    begin
      clk = 1'b0;
      forever
        #2 clk = ~clk;
    end

  initial
    begin
      repeat (RST_CYC + N_TXN * 64) @(posedge clk);
      stop_with_failure("timeout, the transactions did not finish in time");
    end

  initial
    begin
      logic [31:0] a;
      logic [31:0] a2;
      int          sz;
      a = $urandom(32'hafd1_eb18);
      rst <= 1'b1;
      ifu_araddr_i <= '0;
      ifu_arvalid_i <= 1'b0;
      lsu_araddr_i <= '0;
      lsu_arvalid_i <= 1'b0;
      lsu_rstrb_i <= '0;
      lsu_awaddr_i <= '0;
      lsu_wdata_i <= '0;
      lsu_wstrb_i <= '0;
      lsu_wvalid_i <= 1'b0;
      exp_ifu <= '0;
      exp_lsu <= '0;
      exp_arsize <= size_word;
      exp_awsize <= size_word;
      last_lo <= '0;
      lsu_kind <= K_MEM;
      ifu_pend <= 1'b0;
      lsu_pend <= 1'b0;
      wr_pend <= 1'b0;
      conc_mode <= 1'b0;
      test_name = "reset";
      for (int i = 0; i < DEPTH; i++)
        shadow[i] = {32'(i), 32'(i)} ^ KEY;
      repeat (RST_CYC) @(posedge clk);
      rst <= 1'b0;

      // mtime high word stays zero this early
      test_name = "timer";
      for (int i = 0; i < N_TIMER; i++)
        begin
          load_lsu(mtime_lo_addr, 8'h0f, K_LO);
          if (i % 2 == 1)
            load_lsu(mtime_hi_addr, 8'h0f, K_HI);
        end

      test_name = "ifu_fetch";
      for (int i = 0; i < N_IFU; i++)
        read_ifu({rand_addr()} & 32'hffff_fffc);

      // every size at every byte offset
      test_name = "lsu_load";
      for (int i = 0; i < N_LOAD; i++)
        begin
          sz = i % 3;
          a  = (rand_addr() & 32'hffff_fffc) | 32'((i / 3) % 4);
          load_lsu(a, strb_for(sz), K_MEM);
        end

      test_name = "store_load";
      for (int i = 0; i < N_STORE; i++)
        begin
          sz = $urandom % 3;
          a  = rand_addr();
          store_lsu(a, $urandom, strb_for(sz));
          load_lsu(a, strb_for(sz), K_MEM);
        end

      test_name = "concurrent";
      conc_mode <= 1'b1;
      for (int i = 0; i < N_CONC; i++)
        begin
          a  = rand_addr() & 32'hffff_fffc;
          a2 = rand_addr();
          fork
            read_ifu(a);
            load_lsu(a2, strb_for(i % 3), K_MEM);
          join
          n_conc++;
        end
      conc_mode <= 1'b0;
      repeat (4) @(posedge clk);

      if (n_ifu > 0 && n_mem > 0 && n_lo > 0 && n_hi > 0 && n_store > 0 && n_conc > 0)
        begin
          $display("test passed");
          $finish;
        end
      else
        stop_with_failure("some checks were never exercised");
    end

endmodule

`default_nettype wire

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model #(
  parameter int          ADDR_W = 32,
  parameter int          DEPTH  = 256,
  parameter logic [63:0] KEY    = 64'h0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  output logic [63:0]       rdata_o,
  output logic [1:0]        rresp_o,
  output logic              rvalid_o,
  input  logic              rready_i,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [63:0]       wdata_i,
  input  logic [7:0]        wstrb_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  output logic [1:0]        bresp_o,
  output logic              bvalid_o,
  input  logic              bready_i
);
  localparam int IDX_W = $clog2(DEPTH);

  logic [63:0]      mem [DEPTH];
  // read side
  logic             arready_q;
  logic             rd_pend;
  logic [IDX_W-1:0] rd_idx;
  logic [2:0]       rd_wait;
  logic             rvalid_q;
  logic [63:0]      rdata_q;
  // write side
  logic             awready_q;
  logic             wready_q;
  logic             aw_got;
  logic             w_got;
  logic [IDX_W-1:0] wr_idx;
  logic [63:0]      wr_data;
  logic [7:0]       wr_strb;
  logic             b_pend;
  logic [2:0]       b_wait;
  logic             bvalid_q;

  // word index in both halves, scrambled by the key
  initial
    begin
      for (int i = 0; i < DEPTH; i++)
        begin
          mem[i] = {32'(i), 32'(i)} ^ KEY;
        end
    end

  always @(posedge clk)
    begin
      if (rst)
        begin
          arready_q <= 1'b0;
          rd_pend   <= 1'b0;
          rvalid_q  <= 1'b0;
        end
      else
        begin
          // ready low about one cycle in four
          arready_q <= ($urandom % 4) != 0;
          rvalid_q  <= rvalid_q && !rready_i;
          if (arvalid_i && arready_o)
            begin
              rd_pend <= 1'b1;
              rd_idx  <= araddr_i[IDX_W+2:3];
              rd_wait <= 3'($urandom % 5);
            end
          else if (rd_pend)
            begin
              if (rd_wait == 3'd0)
                begin
                  rvalid_q <= 1'b1;
                  rdata_q  <= mem[rd_idx];
                  rd_pend  <= 1'b0;
                end
              else
                begin
                  rd_wait <= rd_wait - 3'd1;
                end
            end
        end
    end

  // one read at a time
  assign arready_o = arready_q && !rd_pend && !rvalid_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = 2'b00;

  always @(posedge clk)
    begin
      if (rst)
        begin
          awready_q <= 1'b0;
          wready_q  <= 1'b0;
          aw_got    <= 1'b0;
          w_got     <= 1'b0;
          b_pend    <= 1'b0;
          bvalid_q  <= 1'b0;
        end
      else
        begin
          awready_q <= ($urandom % 3) != 0;
          wready_q  <= ($urandom % 3) != 0;
          bvalid_q  <= bvalid_q && !bready_i;
          if (awvalid_i && awready_o)
            begin
              aw_got <= 1'b1;
              wr_idx <= awaddr_i[IDX_W+2:3];
            end
          if (wvalid_i && wready_o)
            begin
              w_got   <= 1'b1;
              wr_data <= wdata_i;
              wr_strb <= wstrb_i;
            end
          // commit once address and data are both in
          if (aw_got && w_got && !b_pend)
            begin
              for (int b = 0; b < 8; b++)
                begin
                  if (wr_strb[b])
                    begin
                      mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
              aw_got <= 1'b0;
              w_got  <= 1'b0;
              b_pend <= 1'b1;
              b_wait <= 3'($urandom % 6);
            end
          else if (b_pend)
            begin
              if (b_wait == 3'd0)
                begin
                  bvalid_q <= 1'b1;
                  b_pend   <= 1'b0;
                end
              else
                begin
                  b_wait <= b_wait - 3'd1;
                end
            end
        end
    end

  assign awready_o = awready_q && !aw_got && !b_pend && !bvalid_q;
  assign wready_o  = wready_q && !w_got && !b_pend && !bvalid_q;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = 2'b00;

endmodule

`default_nettype wire

// ==== hdl/cpu_bus_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_top #(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,

  // ifu fetch
  input  logic [ADDR_W-1:0] ifu_araddr_i,
  input  logic              ifu_arvalid_i,
  output logic [31:0]       ifu_rdata_o,
  output logic              ifu_rvalid_o,

  // lsu load
  input  logic [ADDR_W-1:0] lsu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  logic [7:0]        lsu_rstrb_i,
  output logic [31:0]       lsu_rdata_o,
  output logic              lsu_rvalid_o,

  // lsu store
  input  logic [ADDR_W-1:0] lsu_awaddr_i,
  input  logic [31:0]       lsu_wdata_i,
  input  logic [7:0]        lsu_wstrb_i,
  input  logic              lsu_wvalid_i,
  output logic              lsu_wdone_o,

  // axi4 master
  output logic [ADDR_W-1:0] m_araddr_o,
  output logic [2:0]        m_arsize_o,
  output logic              m_arvalid_o,
  input  logic              m_arready_i,
  input  logic [63:0]       m_rdata_i,
  input  logic [1:0]        m_rresp_i,
  input  logic              m_rvalid_i,
  output logic              m_rready_o,
  output logic [ADDR_W-1:0] m_awaddr_o,
  output logic [2:0]        m_awsize_o,
  output logic              m_awvalid_o,
  input  logic              m_awready_i,
  output logic [63:0]       m_wdata_o,
  output logic [7:0]        m_wstrb_o,
  output logic              m_wlast_o,
  output logic              m_wvalid_o,
  input  logic              m_wready_i,
  input  logic [1:0]        m_bresp_i,
  input  logic              m_bvalid_i,
  output logic              m_bready_o
);

  // arbiter to timer
  logic              clint_req;
  logic [ADDR_W-1:0] clint_addr;
  logic [31:0]       clint_rdata;
  logic              clint_rvalid;

  bus_arbiter #(
    .ADDR_W (ADDR_W)
  ) u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_rstrb_i    (lsu_rstrb_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_awaddr_i   (lsu_awaddr_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .lsu_wstrb_i    (lsu_wstrb_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .lsu_wdone_o    (lsu_wdone_o),
    .clint_req_o    (clint_req),
    .clint_addr_o   (clint_addr),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .m_araddr_o     (m_araddr_o),
    .m_arsize_o     (m_arsize_o),
    .m_arvalid_o    (m_arvalid_o),
    .m_arready_i    (m_arready_i),
    .m_rdata_i      (m_rdata_i),
    .m_rresp_i      (m_rresp_i),
    .m_rvalid_i     (m_rvalid_i),
    .m_rready_o     (m_rready_o),
    .m_awaddr_o     (m_awaddr_o),
    .m_awsize_o     (m_awsize_o),
    .m_awvalid_o    (m_awvalid_o),
    .m_awready_i    (m_awready_i),
    .m_wdata_o      (m_wdata_o),
    .m_wstrb_o      (m_wstrb_o),
    .m_wlast_o      (m_wlast_o),
    .m_wvalid_o     (m_wvalid_o),
    .m_wready_i     (m_wready_i),
    .m_bresp_i      (m_bresp_i),
    .m_bvalid_i     (m_bvalid_i),
    .m_bready_o     (m_bready_o)
  );

  // mtime, served inside the subsystem
  clint #(
    .ADDR_W (ADDR_W)
  ) u_clint (
    .clk      (clk),
    .rst      (rst),
    .req_i    (clint_req),
    .addr_i   (clint_addr),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

endmodule

`default_nettype wire

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter #(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,

  // ifu fetch
  input  logic [ADDR_W-1:0] ifu_araddr_i,
  input  logic              ifu_arvalid_i,
  output logic [31:0]       ifu_rdata_o,
  output logic              ifu_rvalid_o,

  // lsu load
  input  logic [ADDR_W-1:0] lsu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  logic [7:0]        lsu_rstrb_i,
  output logic [31:0]       lsu_rdata_o,
  output logic              lsu_rvalid_o,

  // lsu store
  input  logic [ADDR_W-1:0] lsu_awaddr_i,
  input  logic [31:0]       lsu_wdata_i,
  input  logic [7:0]        lsu_wstrb_i,
  input  logic              lsu_wvalid_i,
  output logic              lsu_wdone_o,

  // timer
  output logic              clint_req_o,
  output logic [ADDR_W-1:0] clint_addr_o,
  input  logic [31:0]       clint_rdata_i,
  input  logic              clint_rvalid_i,

  // axi4 master, read
  output logic [ADDR_W-1:0] m_araddr_o,
  output logic [2:0]        m_arsize_o,
  output logic              m_arvalid_o,
  input  logic              m_arready_i,
  input  logic [63:0]       m_rdata_i,
  input  logic [1:0]        m_rresp_i,
  input  logic              m_rvalid_i,
  output logic              m_rready_o,

  // axi4 master, write
  output logic [ADDR_W-1:0] m_awaddr_o,
  output logic [2:0]        m_awsize_o,
  output logic              m_awvalid_o,
  input  logic              m_awready_i,
  output logic [63:0]       m_wdata_o,
  output logic [7:0]        m_wstrb_o,
  output logic              m_wlast_o,
  output logic              m_wvalid_o,
  input  logic              m_wready_i,
  input  logic [1:0]        m_bresp_i,
  input  logic              m_bvalid_i,
  output logic              m_bready_o
);
  import bus_pkg::*;

  // strobe pattern to axi size, anything wider counts as a word
  function automatic logic [2:0] size_of(input logic [7:0] strb);
    logic [2:0] sz;
    case (strb)
      8'h01:   sz = size_byte;
      8'h03:   sz = size_half;
      default: sz = size_word;
    endcase
    return sz;
  endfunction

  // read channel state
  logic              rd_busy_q;
  logic              rd_lsu_q;
  logic              rd_clint_q;
  logic              arvalid_q;
  logic              clint_req_q;
  logic [ADDR_W-1:0] rd_addr_q;
  logic [2:0]        rd_size_q;

  logic              rd_take;
  logic              lsu_timer;
  logic              rd_done;
  logic [31:0]       rd_half;
  logic [31:0]       rd_word;

  // write channel state
  logic              wr_busy_q;
  logic              awvalid_q;
  logic              wvalid_q;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [31:0]       wr_data_q;
  logic [7:0]        wr_strb_q;

  logic              wr_take;
  logic [31:0]       wr_word;
  logic [3:0]        wr_nib;

  // timer hit, only loads from the lsu go to the clint
  assign lsu_timer = lsu_araddr_i == ADDR_W'(mtime_lo_addr) ||
                     lsu_araddr_i == ADDR_W'(mtime_hi_addr);

  // lsu has priority, a new grant only when the channel is idle
  assign rd_take = !rd_busy_q && (lsu_arvalid_i || ifu_arvalid_i);
  // read ends on the clint pulse or on the axi beat
  assign rd_done = rd_busy_q && (rd_clint_q ? clint_rvalid_i : m_rvalid_i);

  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          rd_busy_q   <= 1'b0;
          rd_lsu_q    <= 1'b0;
          rd_clint_q  <= 1'b0;
          arvalid_q   <= 1'b0;
          clint_req_q <= 1'b0;
        end
      else
        begin
          // timer request is a single-cycle strobe
          clint_req_q <= 1'b0;
          if (rd_take)
            begin
              rd_busy_q   <= 1'b1;
              rd_lsu_q    <= lsu_arvalid_i;
              rd_clint_q  <= lsu_arvalid_i && lsu_timer;
              clint_req_q <= lsu_arvalid_i && lsu_timer;
              arvalid_q   <= !(lsu_arvalid_i && lsu_timer);
            end
          else
            begin
              // address accepted, wait for data
              if (arvalid_q && m_arready_i)
                begin
                  arvalid_q <= 1'b0;
                end
              if (rd_done)
                begin
                  rd_busy_q <= 1'b0;
                end
            end
        end
    end

  // granted address and size
  always_ff @(posedge clk)
    begin
      if (rd_take)
        begin
          rd_addr_q <= lsu_arvalid_i ? lsu_araddr_i : ifu_araddr_i;
          rd_size_q <= lsu_arvalid_i ? size_of(lsu_rstrb_i) : size_word;
        end
    end

  assign m_araddr_o   = rd_addr_q;
  assign m_arsize_o   = rd_size_q;
  assign m_arvalid_o  = arvalid_q;
  // requesters always take a response
  assign m_rready_o   = 1'b1;
  assign clint_req_o  = clint_req_q;
  assign clint_addr_o = rd_addr_q;

  // half by bit 2, then drop the low bytes with zero fill
  assign rd_half = rd_addr_q[2] ? m_rdata_i[63:32] : m_rdata_i[31:0];
  assign rd_word = rd_half >> {rd_addr_q[1:0], 3'b000};

  assign ifu_rdata_o  = rd_word;
  assign ifu_rvalid_o = rd_done && !rd_lsu_q;
  assign lsu_rdata_o  = rd_clint_q ? clint_rdata_i : rd_word;
  assign lsu_rvalid_o = rd_done && rd_lsu_q;

  // store, aw and w issued together
  assign wr_take = !wr_busy_q && lsu_wvalid_i;

  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          wr_busy_q <= 1'b0;
          awvalid_q <= 1'b0;
          wvalid_q  <= 1'b0;
        end
      else
        begin
          if (wr_take)
            begin
              wr_busy_q <= 1'b1;
              awvalid_q <= 1'b1;
              wvalid_q  <= 1'b1;
            end
          else
            begin
              // each valid drops on its own ready
              if (awvalid_q && m_awready_i)
                begin
                  awvalid_q <= 1'b0;
                end
              if (wvalid_q && m_wready_i)
                begin
                  wvalid_q <= 1'b0;
                end
              if (wr_busy_q && m_bvalid_i)
                begin
                  wr_busy_q <= 1'b0;
                end
            end
        end
    end

  always_ff @(posedge clk)
    begin
      if (wr_take)
        begin
          wr_addr_q <= lsu_awaddr_i;
          wr_data_q <= lsu_wdata_i;
          wr_strb_q <= lsu_wstrb_i;
        end
    end

  // data and strobe moved up to the byte offset
  assign wr_word = wr_data_q << {wr_addr_q[1:0], 3'b000};
  assign wr_nib  = wr_strb_q[3:0] << wr_addr_q[1:0];

  assign m_awaddr_o  = wr_addr_q;
  assign m_awsize_o  = size_of(wr_strb_q);
  assign m_awvalid_o = awvalid_q;
  // same word in both halves, strobes pick the live one
  assign m_wdata_o   = {wr_word, wr_word};
  assign m_wstrb_o   = wr_addr_q[2] ? {wr_nib, 4'b0000} : {4'b0000, wr_nib};
  // single beat, every beat is the last
  assign m_wlast_o   = wvalid_q;
  assign m_wvalid_o  = wvalid_q;
  assign m_bready_o  = 1'b1;
  assign lsu_wdone_o = wr_busy_q && m_bvalid_i;

  // memory side never reports an error
  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rresp_i == resp_okay);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_bresp_i == resp_okay);

  // ar held with a stable address until the slave takes it
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

endmodule

`default_nettype wire

// ==== hdl/clint.sv ====
`timescale 1ns/1ns
`default_nettype none

module clint #(
  parameter int ADDR_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic [31:0]       rdata_o,
  output logic              rvalid_o
);
  import bus_pkg::*;

  // free-running machine timer
  logic [63:0] mtime_q;
  // read return
  logic [31:0] rdata_q;
  logic        rvalid_q;
  logic        hi_sel;

  // anything but the high word address reads the low word
  assign hi_sel = addr_i == ADDR_W'(mtime_hi_addr);

  always_ff @(posedge clk)
    begin
      if (rst)
        begin
          mtime_q  <= '0;
          rvalid_q <= 1'b0;
        end
      else
        begin
          mtime_q  <= mtime_q + 64'd1;
          // one-cycle answer per request
          rvalid_q <= req_i;
        end
    end

  // word captured in the request cycle
  always_ff @(posedge clk)
    begin
      if (req_i)
        begin
          rdata_q <= hi_sel ? mtime_q[63:32] : mtime_q[31:0];
        end
    end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

  // arbiter issues one request per load and waits for the answer
  a_req_single: assert property (@(posedge clk) disable iff (rst)
    req_i |=> !req_i);

endmodule

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // core-local timer, two 32-bit words of mtime
  localparam logic [31:0] mtime_lo_addr = 32'h0200_bff8;
  localparam logic [31:0] mtime_hi_addr = mtime_lo_addr + 32'd4;

  // axi response codes
  // only okay is ever expected from the memory side
  localparam logic [1:0] resp_okay = 2'b00;

  // axi size field, log2 of bytes per beat
  localparam logic [2:0] size_byte = 3'b000;
  localparam logic [2:0] size_half = 3'b001;
  localparam logic [2:0] size_word = 3'b010;

endpackage

`default_nettype wire
